//--- hdl/board_defs.svh
//======================================================================
// Board-wide widths, memory size and debounce defaults
// Included by the package and by any module that sizes a port or count
//======================================================================
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// Memory geometry, 256 KiB of bytes
`define BOARD_ADDR_WIDTH 18
`define BOARD_DATA_WIDTH 8
`define BOARD_MEM_SIZE 262144
`define BOARD_MAX_ADDR (`BOARD_MEM_SIZE - 1)

// Set-address word from the JTAG host
`define BOARD_JTAG_ADDR_WIDTH 15

// Push button filter
// 500000 cycles is 10 ms at 50 MHz
`define BOARD_DEBOUNCE_CYCLES 500000
`define BOARD_DEBOUNCE_CNT_WIDTH 20

// Seven-segment digit, one bit per segment
`define BOARD_SEG_WIDTH 7

// Status LEDs
// 0 write strobe, 1 data change, 2 button, 3 top limit, 4 bottom limit
`define BOARD_LED_COUNT 5

`endif

//--- hdl/board_pkg.sv
//======================================================================
// Shared types for the memory hub, referenced as board_pkg::name
//======================================================================
`default_nettype none

`include "board_defs.svh"

package board_pkg;

    // Memory address and data
    typedef logic [`BOARD_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`BOARD_DATA_WIDTH-1:0] byte_t;

    // Address word as the host sends it, zero-extended on load
    typedef logic [`BOARD_JTAG_ADDR_WIDTH-1:0] jtag_addr_t;

    // Active-low segment pattern, bit 0 is segment a
    typedef logic [`BOARD_SEG_WIDTH-1:0] seg_t;

    // One hex digit
    typedef logic [3:0] nibble_t;

    // JTAG write FSM
    typedef enum logic [1:0] {
        JTAG_IDLE  = 2'd0,
        JTAG_WRITE = 2'd1,
        JTAG_WAIT  = 2'd2
    } jtag_state_t;

endpackage

`default_nettype wire

//--- hdl/board_top.sv
//======================================================================
// Board memory hub top: JTAG write path, button browsing, RAM, display
//======================================================================
`timescale 1ns/1ns
`default_nettype none

`include "board_defs.svh"

module board_top #(
    parameter int unsigned DEBOUNCE_CYCLES = `BOARD_DEBOUNCE_CYCLES
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        key_up_n,
    input  logic                        key_down_n,
    input  board_pkg::byte_t            jtag_data,
    input  board_pkg::jtag_addr_t       jtag_addr,
    output board_pkg::byte_t            jtag_rdata,
    output board_pkg::seg_t             hex5,
    output board_pkg::seg_t             hex4,
    output board_pkg::seg_t             hex3,
    output board_pkg::seg_t             hex2,
    output logic [`BOARD_LED_COUNT-1:0] led
);

    // RAM port
    logic             mem_we;
    logic             mem_re;
    board_pkg::addr_t mem_addr;
    board_pkg::byte_t mem_wdata;
    board_pkg::byte_t mem_rdata;

    // Status and navigation
    logic             data_changed;
    logic             press_up;
    logic             press_down;
    logic             at_max;
    logic             at_zero;
    board_pkg::addr_t disp_addr;

    //==================================================================
    // JTAG side
    //==================================================================
    jtag_write_ctrl u_jtag_write_ctrl (
        .clk          (clk),
        .rst          (rst),
        .jtag_data    (jtag_data),
        .jtag_addr    (jtag_addr),
        .disp_addr    (disp_addr),
        .mem_we       (mem_we),
        .mem_re       (mem_re),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .data_changed (data_changed)
    );

    //==================================================================
    // Buttons and display address
    //==================================================================
    key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_key_up (
        .clk   (clk),
        .rst   (rst),
        .key_n (key_up_n),
        .press (press_up)
    );

    key_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_key_down (
        .clk   (clk),
        .rst   (rst),
        .key_n (key_down_n),
        .press (press_down)
    );

    display_nav u_display_nav (
        .clk       (clk),
        .rst       (rst),
        .up        (press_up),
        .down      (press_down),
        .disp_addr (disp_addr),
        .at_max    (at_max),
        .at_zero   (at_zero)
    );

    //==================================================================
    // Memory and display
    //==================================================================
    byte_ram u_byte_ram (
        .clk   (clk),
        .we    (mem_we),
        .re    (mem_re),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    seg_display u_seg_display (
        .clk       (clk),
        .rst       (rst),
        .disp_addr (disp_addr),
        .rdata     (mem_rdata),
        .hex5      (hex5),
        .hex4      (hex4),
        .hex3      (hex3),
        .hex2      (hex2)
    );

    // Host reads back whatever the display read returns
    assign jtag_rdata = mem_rdata;

    // LED 0 write strobe up to LED 4 bottom limit
    assign led = {at_zero, at_max, press_up | press_down, data_changed, mem_we};

endmodule

`default_nettype wire

//--- hdl/byte_ram.sv
//======================================================================
// Single-port byte RAM, synchronous write and registered read
//======================================================================
`timescale 1ns/1ns
`default_nettype none

`include "board_defs.svh"

module byte_ram (
    input  logic             clk,
    input  logic             we,
    input  logic             re,
    input  board_pkg::addr_t addr,
    input  board_pkg::byte_t wdata,
    output board_pkg::byte_t rdata
);

    board_pkg::byte_t mem [0:`BOARD_MEM_SIZE-1];

    // Write has the port, read data holds its last value meanwhile
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/display_nav.sv
//======================================================================
// Display address stepped by button pulses, saturating at both ends
//======================================================================
`timescale 1ns/1ns
`default_nettype none

`include "board_defs.svh"

module display_nav (
    input  logic             clk,
    input  logic             rst,
    input  logic             up,
    input  logic             down,
    output board_pkg::addr_t disp_addr,
    output logic             at_max,
    output logic             at_zero
);

    localparam board_pkg::addr_t MAX_ADDR = board_pkg::addr_t'(`BOARD_MAX_ADDR);

    // Limit flags, also used to stop the count
    assign at_max  = (disp_addr == MAX_ADDR);
    assign at_zero = (disp_addr == '0);

    // Up has precedence when both pulses land together
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            disp_addr <= '0;
        end else if (up) begin
            if (!at_max) begin
                disp_addr <= disp_addr + 1'b1;
            end
        end else if (down) begin
            if (!at_zero) begin
                disp_addr <= disp_addr - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/jtag_write_ctrl.sv
//======================================================================
// JTAG host input sampling, write FSM, write pointer and RAM port mux
// Writes go first, the display read gets the port in every other cycle
//======================================================================
`timescale 1ns/1ns
`default_nettype none

module jtag_write_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  board_pkg::byte_t       jtag_data,
    input  board_pkg::jtag_addr_t  jtag_addr,
    input  board_pkg::addr_t       disp_addr,
    output logic                   mem_we,
    output logic                   mem_re,
    output board_pkg::addr_t       mem_addr,
    output board_pkg::byte_t       mem_wdata,
    output logic                   data_changed
);

    //==================================================================
    // Input sampling and change detection
    //==================================================================
    board_pkg::byte_t       data_sync;
    board_pkg::byte_t       data_prev;
    board_pkg::jtag_addr_t  addr_sync;
    board_pkg::jtag_addr_t  addr_prev;
    logic                   addr_changed;

    // Host holds both words as levels, any change is an event
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_sync    <= '0;
            data_prev    <= '0;
            data_changed <= 1'b0;
            addr_sync    <= '0;
            addr_prev    <= '0;
            addr_changed <= 1'b0;
        end else begin
            data_sync    <= jtag_data;
            data_prev    <= data_sync;
            data_changed <= (data_sync != data_prev);
            addr_sync    <= jtag_addr;
            addr_prev    <= addr_sync;
            addr_changed <= (addr_sync != addr_prev);
        end
    end

    //==================================================================
    // Write FSM, IDLE then WRITE then WAIT
    //==================================================================
    board_pkg::jtag_state_t state;
    board_pkg::jtag_state_t state_next;
    board_pkg::byte_t       wdata_reg;
    board_pkg::addr_t       wr_ptr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= board_pkg::JTAG_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Changes seen outside IDLE are dropped
    always_comb begin
        state_next = state;
        case (state)
            board_pkg::JTAG_IDLE: begin
                if (data_changed) begin
                    state_next = board_pkg::JTAG_WRITE;
                end
            end
            board_pkg::JTAG_WRITE: state_next = board_pkg::JTAG_WAIT;
            board_pkg::JTAG_WAIT:  state_next = board_pkg::JTAG_IDLE;
            default:               state_next = board_pkg::JTAG_IDLE;
        endcase
    end

    // Byte captured as the FSM leaves IDLE, held through the write
    always_ff @(posedge clk) begin
        if (state == board_pkg::JTAG_IDLE && data_changed) begin
            wdata_reg <= data_sync;
        end
    end

    // New host address wins over the post-write increment
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (addr_changed) begin
            wr_ptr <= board_pkg::addr_t'(addr_sync);
        end else if (state == board_pkg::JTAG_WRITE) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    //==================================================================
    // RAM port select
    //==================================================================
    assign mem_we    = (state == board_pkg::JTAG_WRITE);
    assign mem_re    = ~mem_we;
    assign mem_addr  = mem_we ? wr_ptr : disp_addr;
    assign mem_wdata = wdata_reg;

endmodule

`default_nettype wire

//--- hdl/key_debounce.sv
//======================================================================
// One active-low push button: synchronize, filter, pulse on press
//======================================================================
`timescale 1ns/1ns
`default_nettype none

`include "board_defs.svh"

module key_debounce #(
    parameter int unsigned DEBOUNCE_CYCLES = `BOARD_DEBOUNCE_CYCLES
) (
    input  logic clk,
    input  logic rst,
    input  logic key_n,
    output logic press
);

    localparam int unsigned CW = `BOARD_DEBOUNCE_CNT_WIDTH;
    localparam logic [CW-1:0] CNT_LIMIT = CW'(DEBOUNCE_CYCLES);

    logic          key_sync1;
    logic          key_sync2;
    logic          key_stable;
    logic          key_prev;
    logic [CW-1:0] cnt;

    // Two flops against metastability, idle level is high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_sync1 <= 1'b1;
            key_sync2 <= 1'b1;
        end else begin
            key_sync1 <= key_n;
            key_sync2 <= key_sync1;
        end
    end

    // Stable level follows only after CNT_LIMIT + 1 cycles of difference
    // Any bounce back to the stable level restarts the count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt        <= '0;
            key_stable <= 1'b1;
        end else if (key_sync2 == key_stable) begin
            cnt <= '0;
        end else if (cnt == CNT_LIMIT) begin
            cnt        <= '0;
            key_stable <= key_sync2;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_prev <= 1'b1;
        end else begin
            key_prev <= key_stable;
        end
    end

    // High to low of the filtered level, one cycle wide
    assign press = key_prev & ~key_stable;

endmodule

`default_nettype wire

//--- hdl/seg_display.sv
//======================================================================
// Seven-segment output: address low byte on HEX5-4, data on HEX3-2
//======================================================================
`timescale 1ns/1ns
`default_nettype none

module seg_display (
    input  logic             clk,
    input  logic             rst,
    input  board_pkg::addr_t disp_addr,
    input  board_pkg::byte_t rdata,
    output board_pkg::seg_t  hex5,
    output board_pkg::seg_t  hex4,
    output board_pkg::seg_t  hex3,
    output board_pkg::seg_t  hex2
);

    // Active low, segment a in bit 0, covers 0 to F
    function automatic board_pkg::seg_t hex_to_seg(input board_pkg::nibble_t val);
        board_pkg::seg_t seg;
        case (val)
            4'h0:    seg = 7'b1000000;
            4'h1:    seg = 7'b1111001;
            4'h2:    seg = 7'b0100100;
            4'h3:    seg = 7'b0110000;
            4'h4:    seg = 7'b0011001;
            4'h5:    seg = 7'b0010010;
            4'h6:    seg = 7'b0000010;
            4'h7:    seg = 7'b1111000;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0010000;
            4'hA:    seg = 7'b0001000;
            4'hB:    seg = 7'b0000011;
            4'hC:    seg = 7'b1000110;
            4'hD:    seg = 7'b0100001;
            4'hE:    seg = 7'b0000110;
            4'hF:    seg = 7'b0001110;
            default: seg = 7'b1111111;
        endcase
        return seg;
    endfunction

    //==================================================================
    // Data path
    //==================================================================
    board_pkg::byte_t data_reg;

    // One more stage after the RAM read register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            data_reg <= '0;
        end else begin
            data_reg <= rdata;
        end
    end

    // Address digits straight from the pointer
    assign hex5 = hex_to_seg(disp_addr[7:4]);
    assign hex4 = hex_to_seg(disp_addr[3:0]);

    // Data digits from the registered byte
    assign hex3 = hex_to_seg(data_reg[7:4]);
    assign hex2 = hex_to_seg(data_reg[3:0]);

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the memory hub testbench with Verilator and run it
# A build or run that ends abnormally also counts as a failure
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module board_tb -o board_sim \
    && ./obj_dir/board_sim > sim.log 2>&1 \
    || echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

//--- sources.f
+incdir+hdl
hdl/board_pkg.sv
hdl/jtag_write_ctrl.sv
hdl/key_debounce.sv
hdl/display_nav.sv
hdl/byte_ram.sv
hdl/seg_display.sv
hdl/board_top.sv
test/board_asserts.sv
test/board_tb.sv

//--- test/board_asserts.sv
//======================================================================
// Protocol checks on the JTAG write FSM and RAM port, bound in by type
//======================================================================
`timescale 1ns/1ns
`default_nettype none

module board_asserts (
    input logic                   clk,
    input logic                   rst,
    input logic                   mem_we,
    input logic                   mem_re,
    input board_pkg::jtag_state_t state
);

    // Write strobe is a single cycle
    property p_we_single;
        @(posedge clk) disable iff (rst) mem_we |=> !mem_we;
    endproperty

    // Every write cycle is followed by the wait cycle
    property p_write_then_wait;
        @(posedge clk) disable iff (rst)
            (state == board_pkg::JTAG_WRITE) |=> (state == board_pkg::JTAG_WAIT);
    endproperty

    // Port is owned by one side only
    property p_port_exclusive;
        @(posedge clk) disable iff (rst) !(mem_we && mem_re);
    endproperty

    a_we_single: assert property (p_we_single)
        else $error("mem_we stayed high for two cycles");
    a_write_then_wait: assert property (p_write_then_wait)
        else $error("JTAG_WRITE not followed by JTAG_WAIT");
    a_port_exclusive: assert property (p_port_exclusive)
        else $error("mem_we and mem_re high together");

endmodule

bind jtag_write_ctrl board_asserts u_board_asserts (
    .clk    (clk),
    .rst    (rst),
    .mem_we (mem_we),
    .mem_re (mem_re),
    .state  (state)
);

`default_nettype wire

//--- test/board_tb.sv
//======================================================================
// Testbench for board_top: JTAG writes, button browsing, display checks
// Outputs are compared against a memory, pointer and address model
//======================================================================
`timescale 1ns/1ns
`default_nettype none

`include "board_defs.svh"

module board_tb;

    localparam int unsigned DEB_CYCLES = 4;
    localparam int unsigned SEED       = 32'h2a54_33b5;
    // Stimulus runs near 1000 cycles, limit leaves a wide margin
    localparam int unsigned MAX_CYCLES = 4000;
    localparam board_pkg::addr_t MAX_ADDR = board_pkg::addr_t'(`BOARD_MAX_ADDR);

    logic                        clk;
    logic                        rst;
    logic                        key_up_n;
    logic                        key_down_n;
    board_pkg::byte_t            jtag_data;
    board_pkg::jtag_addr_t       jtag_addr;
    board_pkg::byte_t            jtag_rdata;
    board_pkg::seg_t             hex5;
    board_pkg::seg_t             hex4;
    board_pkg::seg_t             hex3;
    board_pkg::seg_t             hex2;
    logic [`BOARD_LED_COUNT-1:0] led;

    // Reference model state
    board_pkg::byte_t mem_model [board_pkg::addr_t];
    board_pkg::addr_t model_ptr;
    board_pkg::addr_t exp_addr;
    // Press, data change and write strobe LEDs expected at the next check
    logic [2:0]       exp_pulse;

    logic check_pending;
    int   error_count;
    int   checks_done;
    int   cycle_count;

    board_top #(.DEBOUNCE_CYCLES(DEB_CYCLES)) UUT (
        .clk        (clk),
        .rst        (rst),
        .key_up_n   (key_up_n),
        .key_down_n (key_down_n),
        .jtag_data  (jtag_data),
        .jtag_addr  (jtag_addr),
        .jtag_rdata (jtag_rdata),
        .hex5       (hex5),
        .hex4       (hex4),
        .hex3       (hex3),
        .hex2       (hex2),
        .led        (led)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //==================================================================
    // Reference functions
    //==================================================================
    // Segments lit per digit, gfedcba, inverted for the active-low board
    function automatic board_pkg::seg_t seg_ref(input board_pkg::nibble_t val);
        logic [6:0] lit [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                                 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
        return ~lit[val];
    endfunction

    // Unwritten locations read as zero
    function automatic board_pkg::byte_t model_read(input board_pkg::addr_t a);
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return 8'h00;
    endfunction

    //==================================================================
    // Compare tasks
    //==================================================================
    task automatic fail_now(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_byte(input string name, input board_pkg::byte_t got,
                              input board_pkg::byte_t exp);
        if (got !== exp) begin
            error_count++;
            fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_seg(input string name, input board_pkg::seg_t got,
                             input board_pkg::seg_t exp);
        if (got !== exp) begin
            error_count++;
            fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_led(input logic [`BOARD_LED_COUNT-1:0] got,
                             input logic [`BOARD_LED_COUNT-1:0] exp);
        if (got !== exp) begin
            error_count++;
            fail_now($sformatf("Mismatch led: got %h expected %h", got, exp));
        end
    endtask

    // Display and limits from the model, pulse LEDs from the stimulus timing
    task automatic compare_outputs();
        board_pkg::byte_t            exp_data;
        logic [`BOARD_LED_COUNT-1:0] exp_led;
        exp_data = model_read(exp_addr);
        exp_led  = {exp_addr == '0, exp_addr == MAX_ADDR, exp_pulse};
        check_byte("jtag_rdata", jtag_rdata, exp_data);
        check_seg("hex5", hex5, seg_ref(exp_addr[7:4]));
        check_seg("hex4", hex4, seg_ref(exp_addr[3:0]));
        check_seg("hex3", hex3, seg_ref(exp_data[7:4]));
        check_seg("hex2", hex2, seg_ref(exp_data[3:0]));
        check_led(led, exp_led);
        checks_done++;
    endtask

    // Compare on the falling edge, away from the driving edge
    always @(negedge clk) begin
        if (check_pending) begin
            compare_outputs();
            check_pending = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: test did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "Simulation stopped by timeout");
        end
    end

    //==================================================================
    // Stimulus tasks
    //==================================================================
    task automatic settle(input int n);
        repeat (n) @(posedge clk);
        check_pending = 1'b1;
        wait (check_pending == 1'b0);
    endtask

    // New host address reloads the model pointer
    task automatic set_host_addr(input board_pkg::jtag_addr_t a);
        @(posedge clk);
        jtag_addr <= a;
        model_ptr = board_pkg::addr_t'(a);
        settle(8);
    endtask

    // Change pulse after edge 2, write strobe after edge 3, RAM written at edge 4
    task automatic host_write(input board_pkg::byte_t b);
        @(posedge clk);
        jtag_data <= b;
        exp_pulse = 3'b010;
        settle(2);
        exp_pulse = 3'b001;
        settle(1);
        exp_pulse = 3'b000;
        mem_model[model_ptr] = b;
        model_ptr = model_ptr + 18'd1;
        settle(5);
    endtask

    // Press pulse after 2 sync edges and DEB_CYCLES + 1 cycles of difference
    // Hold 10, release 10, settle 6, then check
    task automatic press_key(input logic up);
        @(posedge clk);
        if (up) key_up_n <= 1'b0;
        else key_down_n <= 1'b0;
        exp_pulse = 3'b100;
        settle(DEB_CYCLES + 3);
        exp_pulse = 3'b000;
        repeat (10 - DEB_CYCLES - 3) @(posedge clk);
        key_up_n   <= 1'b1;
        key_down_n <= 1'b1;
        repeat (10) @(posedge clk);
        if (up && exp_addr != MAX_ADDR) begin
            exp_addr = exp_addr + 18'd1;
        end else if (!up && exp_addr != '0) begin
            exp_addr = exp_addr - 18'd1;
        end
        settle(6);
    endtask

    // Too short for the filter, address must not move
    task automatic glitch_key();
        @(posedge clk);
        key_up_n <= 1'b0;
        repeat (2) @(posedge clk);
        key_up_n <= 1'b1;
        settle(20);
    endtask

    //==================================================================
    // Test sequence
    //==================================================================
    initial begin
        int               i;
        int unsigned      seed_val;
        board_pkg::byte_t b;
        board_pkg::byte_t prev;
        rst           = 1'b1;
        key_up_n      = 1'b1;
        key_down_n    = 1'b1;
        jtag_data     = '0;
        jtag_addr     = '0;
        model_ptr     = '0;
        exp_addr      = '0;
        exp_pulse     = 3'b000;
        check_pending = 1'b0;
        error_count   = 0;
        checks_done   = 0;
        cycle_count   = 0;
        seed_val      = $urandom(SEED);
        prev          = 8'h00;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        settle(4);

        // Stream of 8 bytes from address 2
        set_host_addr(15'd2);
        for (i = 0; i < 8; i++) begin
            b = board_pkg::byte_t'($urandom());
            if (b == prev) b = b + 8'd1;
            host_write(b);
            prev = b;
        end

        // Pointer reload, 3 bytes from address 12
        set_host_addr(15'd12);
        for (i = 0; i < 3; i++) begin
            b = board_pkg::byte_t'($urandom());
            if (b == prev) b = b + 8'd1;
            host_write(b);
            prev = b;
        end

        // Browse across both written ranges
        for (i = 0; i < 14; i++) begin
            press_key(1'b1);
        end
        // Back down, two extra presses at zero
        for (i = 0; i < 16; i++) begin
            press_key(1'b0);
        end
        glitch_key();

        $display("%0d output checks done", checks_done);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
